//--- fade_palette.mem
// one 15-bit word per entry, hex: green 14..10, red 9..5, blue 4..0
03E0
0F80
1B20
26C0
3260
3E00
49A0
5540
60E0
6C80
7820
7C00
7003
6406
5809
4C0C
400F
3412
2815
1C18
101B
041E
005F
00BC
0119
0176
01D3
0230
028D
02EA
0347
03A4

//--- neopixel_stim.txt
// columns, all hex: run low_power frames idle
// frames are decoded first, then idle cycles are watched with the inputs held
// first frame after reset, dimmed widening
1 1 1 0
1 1 3 0
// full widening
1 0 2 0
// run low, line must stay quiet
0 0 0 bb8
1 0 1 0
0 1 0 7d0
// 28 frames, offset runs past 31 and wraps
1 1 1c 0
1 0 2 0

//--- src.f
neo_pkg.sv
frame_sequencer.sv
fade_palette_rom.sv
neopixel_serializer.sv
neopixel_top.sv
neopixel_properties.sv
tb_neopixel.sv

//--- tb_neopixel.sv
/* neopixel chain driver testbench: steps through the stim file, decodes dout
   into pixels and checks them against the fading palette */
`timescale 1ns/1ps
`default_nettype none

module tb_neopixel;
  import neo_pkg::*;

  localparam int max_rows     = 16;
  localparam int frame_budget = 3960;   // clocks allowed per frame in the timeout
  localparam int gap_min      = reset_ticks * tick_count;
  localparam int frame_bits   = num_pixels * pixel_w;

  logic clk = 1'b0;
  logic rst_n;
  logic run;
  logic low_power;
  wire  dout;

  logic [color_w-1:0] palette [0:palette_depth-1];
  logic [31:0]        stim_mem [0:4*max_rows-1];   // four words per row

  int err_cnt = 0;
  int check_cnt = 0;
  int err_total;
  int num_rows;
  int cycle_limit = 0;
  int cycle_cnt = 0;
  bit limit_ready = 1'b0;
  int target;
  logic lp_cur = 1'b0;        // widening expected for the frame in flight

  // decoder state
  logic        prev_dout;
  int          hi_cnt;
  int          lo_cnt;        // low clocks since the last fall
  int          last_hi;
  int          bits_in_frame;
  int          frames_done;   // also the expected palette offset
  logic [23:0] pix_shift;
  logic        bit_val;

  neopixel_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .low_power (low_power),
    .dout      (dout)
  );

  always #10 clk = ~clk;      // 20 ns period

  //////////////////////////////
  // expected values
  //////////////////////////////
  // 5-bit channel to a byte
  function automatic logic [7:0] expand_channel(input logic [4:0] field, input logic lp);
    logic [7:0] v;
    v = {3'b000, field};
    return lp ? (v << 1) : (v << 3);   // dimmed keeps two top zeros
  endfunction

  function automatic logic [23:0] expected_pixel(input int entry, input logic lp);
    logic [color_w-1:0] word;
    word = palette[entry % palette_depth];
    return {expand_channel(word[14:10], lp), expand_channel(word[9:5], lp),
            expand_channel(word[4:0], lp)};   // green, red, blue on the wire
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    check_cnt++;
    assert (got == exp)
    else
    begin
      err_cnt++;
      $display("Error at %0d ns: %s is %0d (0x%0h), expected %0d (0x%0h)",
               $time, what, got, got, exp, exp);
    end
  endtask

  //////////////////////////////
  // dout decoder
  //////////////////////////////
  // samples the value dout held during the clock just ended
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      prev_dout     = 1'b0;
      hi_cnt        = 0;
      lo_cnt        = 0;
      last_hi       = 0;
      bits_in_frame = 0;
      frames_done   = 0;
      pix_shift     = '0;
    end
    else
    begin
      if (dout)
      begin
        if (!prev_dout)                        // rise opens a bit
        begin
          if (bits_in_frame == 0)
          begin
            check_cnt++;
            assert (lo_cnt >= gap_min)
            else
            begin
              err_cnt++;
              $display("Error at %0d ns: gap before frame %0d is %0d clocks, need %0d",
                       $time, frames_done, lo_cnt, gap_min);
            end
          end
          else
            check_value(last_hi + lo_cnt, bit_period, "bit period");
          hi_cnt = 0;
        end
        hi_cnt++;
      end
      else
      begin
        if (prev_dout)                         // fall, bit value is known
        begin
          check_cnt++;
          assert (hi_cnt == bit1_hi || hi_cnt == bit0_hi)
          else
          begin
            err_cnt++;
            $display("Error at %0d ns: high pulse of %0d clocks", $time, hi_cnt);
          end
          bit_val   = (hi_cnt == bit1_hi);
          pix_shift = {pix_shift[22:0], bit_val};   // msb arrives first
          last_hi   = hi_cnt;
          lo_cnt    = 0;
          bits_in_frame++;
          if (bits_in_frame % pixel_w == 0)
            check_value(pix_shift, expected_pixel(frames_done + bits_in_frame / pixel_w - 1,
                        lp_cur), $sformatf("frame %0d pixel %0d", frames_done,
                        bits_in_frame / pixel_w - 1));
          if (bits_in_frame == frame_bits)
          begin
            frames_done++;
            bits_in_frame = 0;
          end
        end
        lo_cnt++;
      end
      prev_dout = dout;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  initial
  begin
    rst_n     = 1'b0;
    run       = 1'b0;
    low_power = 1'b0;
    $readmemh("fade_palette.mem", palette);
    $readmemh("neopixel_stim.txt", stim_mem);
    num_rows = 0;
    while (num_rows < max_rows && !$isunknown(stim_mem[4*num_rows]))
      num_rows++;                              // unread rows stay x
    cycle_limit = 1000;
    for (int r = 0; r < num_rows; r++)
      cycle_limit += stim_mem[4*r+2] * frame_budget + stim_mem[4*r+3];
    limit_ready = 1'b1;

    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    for (int r = 0; r < num_rows; r++)
    begin
      @(negedge clk);
      run       = stim_mem[4*r][0];
      low_power = stim_mem[4*r+1][0];
      lp_cur    = stim_mem[4*r+1][0];
      target    = frames_done + stim_mem[4*r+2];
      while (frames_done < target)
        @(negedge clk);
      while (bits_in_frame != 0 || lo_cnt < 20)   // line settled low
        @(negedge clk);
      repeat (stim_mem[4*r+3])
      begin
        @(negedge clk);
        if (!run)
        begin
          check_cnt++;
          assert (dout === 1'b0)
          else
          begin
            err_cnt++;
            $display("Error at %0d ns: dout is %b while run is low", $time, dout);
          end
        end
      end
    end

    err_total = err_cnt + dut.u_ser.u_props.prop_fails;
    $display("errors: %0d, checks: %0d, frames: %0d", err_total, check_cnt, frames_done);
    if (err_total == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // cycle counter against the budget from the stim file
  initial
  begin
    wait (limit_ready);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("errors: %0d, checks: %0d, frames: %0d", err_cnt, check_cnt, frames_done);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- neopixel_properties.sv
/* serial waveform properties, bound into the neopixel serializer */
`timescale 1ns/1ps
`default_nettype none

module neopixel_properties (
  input wire                         clk,
  input wire                         rst_n,
  input wire                         sof,
  input wire                         busy,
  input wire                         eof,
  input wire                         dout
);
  import neo_pkg::*;

  int prop_fails = 0;   // read by the testbench at the end

  //////////////////////////////
  // line shape
  //////////////////////////////
  // a high pulse is the start of one bit, 5 or 10 clocks long
  property high_pulse_width;
    @(posedge clk) disable iff (!rst_n)
      $rose(dout) |-> (dout[*bit0_hi] ##1 !dout) or (dout[*bit1_hi] ##1 !dout);
  endproperty

  // start strobe only while no frame is in flight
  property sof_in_gap;
    @(posedge clk) disable iff (!rst_n)
      sof |-> !busy;
  endproperty

  property eof_single;
    @(posedge clk) disable iff (!rst_n)
      eof |=> !eof;                          // strobe, never a level
  endproperty

  a_high_pulse_width: assert property (high_pulse_width)
  else
  begin
    prop_fails++;
    $error("dout high pulse is neither 5 nor 10 clocks");
  end

  a_sof_in_gap: assert property (sof_in_gap)
  else
  begin
    prop_fails++;
    $error("sof seen while a frame is in flight");
  end

  a_eof_single: assert property (eof_single)
  else
  begin
    prop_fails++;
    $error("eof high in two successive clocks");
  end

endmodule

bind neopixel_serializer neopixel_properties u_props (
  .clk   (clk),
  .rst_n (rst_n),
  .sof   (sof),
  .busy  (busy),
  .eof   (eof),
  .dout  (dout)
);

`default_nettype wire

//--- neopixel_top.sv
/* neopixel chain driver top: frame sequencer, palette ROM and serializer */
`timescale 1ns/1ps
`default_nettype none

module neopixel_top (
  input  wire   clk,
  input  wire   rst_n,
  input  wire   run,        // level, lets new frames start
  input  wire   low_power,  // level, dimmed colour widening
  output logic  dout        // serial data to first LED
);
  import neo_pkg::*;

  frame_phase_t               phase;
  logic                       sof;
  logic                       eof;
  logic [palette_addr_w-1:0]  offset;
  logic [pix_addr_w-1:0]      rd_addr;
  logic [pixel_w-1:0]         rd_data;

  //////////////////////////////
  // producer, buffer, consumer
  //////////////////////////////
  frame_sequencer u_seq (
    .clk    (clk),
    .rst_n  (rst_n),
    .run    (run),
    .eof    (eof),
    .phase  (phase),
    .sof    (sof),
    .offset (offset)
  );

  fade_palette_rom u_rom (
    .clk       (clk),
    .rd_addr   (rd_addr),
    .offset    (offset),
    .low_power (low_power),
    .rd_data   (rd_data)
  );

  neopixel_serializer u_ser (
    .clk     (clk),
    .rst_n   (rst_n),
    .phase   (phase),
    .sof     (sof),
    .rd_data (rd_data),
    .rd_addr (rd_addr),
    .eof     (eof),
    .dout    (dout)
  );

endmodule

`default_nettype wire

//--- neopixel_serializer.sv
/* neopixel serializer: shapes the WS2812B waveform, one 15-clock bit at a time,
   24 bits per pixel msb first, eight pixels per frame */
`timescale 1ns/1ps
`default_nettype none

module neopixel_serializer (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire neo_pkg::frame_phase_t          phase,
  input  wire                                 sof,      // frame start strobe
  input  wire [neo_pkg::pixel_w-1:0]          rd_data,  // next pixel from ROM
  output logic [neo_pkg::pix_addr_w-1:0]      rd_addr,  // pixel to fetch next
  output logic                                eof,      // one clock, frame done
  output logic                                dout      // serial line to chain
);
  import neo_pkg::*;

  logic                   busy;       // bits are going out
  logic [bit_cnt_w-1:0]   bit_cnt;    // clock within current bit
  logic                   bit_end;
  logic                   drop0;
  logic                   drop1;
  logic                   drop;       // end of high time for current bit
  logic [pixel_w-1:0]     shift_q;    // msb is the bit on the line
  logic [bit_idx_w-1:0]   bit_idx;
  logic [pix_addr_w-1:0]  pix_idx;    // pixel being shifted
  logic                   pix_end;
  logic                   frame_end;

  //////////////////////////////
  // bit timing pulses
  //////////////////////////////
  assign bit_end   = busy && (bit_cnt == bit_cnt_w'(bit_period - 1));
  assign drop0     = bit_cnt == bit_cnt_w'(bit0_hi - 1);   // last high clock of a 0
  assign drop1     = bit_cnt == bit_cnt_w'(bit1_hi - 1);   // last high clock of a 1
  assign drop      = shift_q[pixel_w-1] ? drop1 : drop0;
  assign pix_end   = bit_end && (bit_idx == bit_idx_w'(pixel_w - 1));
  assign frame_end = pix_end && (pix_idx == pix_addr_w'(num_pixels - 1));

  // bit-time counter, parked at 0 between frames
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (sof || bit_end || !busy)
      bit_cnt <= '0;
    else
      bit_cnt <= bit_cnt + 1'b1;
  end

  //////////////////////////////
  // line control and pointers
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      dout    <= 1'b0;
      eof     <= 1'b0;
      rd_addr <= '0;
      pix_idx <= '0;
      bit_idx <= '0;
    end
    else
    begin
      eof <= 1'b0;                                 // strobe by default
      if (sof)
      begin
        busy    <= 1'b1;
        dout    <= 1'b1;                           // first bit starts high
        bit_idx <= '0;
        pix_idx <= '0;
        rd_addr <= pix_addr_w'(1);                 // pixel 0 already waiting
      end
      else if (frame_end)
      begin
        busy <= 1'b0;
        dout <= 1'b0;                              // hold low for the gap
        eof  <= 1'b1;
      end
      else if (bit_end)
      begin
        dout <= 1'b1;                              // every bit opens high
        if (pix_end)
        begin
          bit_idx <= '0;
          pix_idx <= pix_idx + 1'b1;
          rd_addr <= rd_addr + 1'b1;               // prefetch, wraps after 7
        end
        else
          bit_idx <= bit_idx + 1'b1;
      end
      else if (busy)
      begin
        if (drop)
          dout <= 1'b0;
      end
      else if (phase == phase_gap)
        rd_addr <= '0;                             // ready for next frame
    end
  end

  // pixel shift register
  always_ff @(posedge clk)
  begin
    if (sof || (pix_end && !frame_end))
      shift_q <= rd_data;                          // load next pixel
    else if (bit_end)
      shift_q <= {shift_q[pixel_w-2:0], 1'b0};     // msb first
  end

endmodule

`default_nettype wire

//--- fade_palette_rom.sv
/* fading palette ROM: registered read at offset plus pixel address,
   5-bit channels widened to bytes in green, red, blue order */
`timescale 1ns/1ps
`default_nettype none

module fade_palette_rom (
  input  wire                                 clk,
  input  wire [neo_pkg::pix_addr_w-1:0]       rd_addr,
  input  wire [neo_pkg::palette_addr_w-1:0]   offset,
  input  wire                                 low_power,  // level, dimmed widening
  output logic [neo_pkg::pixel_w-1:0]         rd_data     // one clock after address
);
  import neo_pkg::*;

  logic [color_w-1:0]         palette [palette_depth];
  logic [palette_addr_w-1:0]  rom_addr;
  logic [color_w-1:0]         pal_word;

  // 5-bit field to one byte
  // low power keeps the top two bits clear to spare the 5 V supply
  function automatic logic [7:0] widen(input logic [4:0] field, input logic lp);
    if (lp)
      return {2'b00, field, 1'b0};
    return {field, 3'b000};           // full scale, field in the top bits
  endfunction

  initial
  begin
    $readmemh("fade_palette.mem", palette);
  end

  assign rom_addr = offset + palette_addr_w'(rd_addr);   // wraps mod 32
  assign pal_word = palette[rom_addr];

  // green 14..10, red 9..5, blue 4..0
  always_ff @(posedge clk)
  begin
    rd_data <= {widen(pal_word[14:10], low_power),
                widen(pal_word[9:5],   low_power),
                widen(pal_word[4:0],   low_power)};
  end

endmodule

`default_nettype wire

//--- frame_sequencer.sv
/* frame sequencer: times the reset gap, starts each frame when run allows
   and steps the palette offset once per completed frame */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire                                 run,     // level, gates new frames
  input  wire                                 eof,     // last bit of frame sent
  output neo_pkg::frame_phase_t               phase,
  output logic                                sof,     // one clock, frame start
  output logic [neo_pkg::palette_addr_w-1:0]  offset   // palette start entry
);
  import neo_pkg::*;

  frame_phase_t           frame_st;   // phase request, phase lags it by one
  logic [tick_cnt_w-1:0]  tick_cnt;
  logic                   tick;       // 10 us strobe
  logic [gap_cnt_w-1:0]   gap_cnt;    // ticks seen in the gap
  logic                   gap_done;

  assign tick     = tick_cnt == tick_cnt_w'(tick_count - 1);
  assign gap_done = gap_cnt == gap_cnt_w'(reset_ticks - 1);

  //////////////////////////////
  // 10 us time base
  //////////////////////////////
  // restarts at every gap so the gap is never short
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tick_cnt <= '0;
    else if (frame_st == phase_data || tick)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 1'b1;
  end

  //////////////////////////////
  // gap counter and frame state
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_st <= phase_gap;
      gap_cnt  <= '0;
    end
    else if (frame_st == phase_data)
    begin
      if (eof)
        frame_st <= phase_gap;           // back to latch time
    end
    else if (tick)
    begin
      if (!gap_done)
        gap_cnt <= gap_cnt + 1'b1;
      else if (run)                      // held at limit while run is low
      begin
        frame_st <= phase_data;
        gap_cnt  <= '0;
      end
    end
  end

  // delayed copy, the one-clock difference is the start strobe
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      phase <= phase_gap;
    else
      phase <= frame_st;
  end

  assign sof = (frame_st == phase_data) && (phase == phase_gap);

  // palette offset, one step per frame sent
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      offset <= '0;
    else if (eof)
      offset <= (offset == palette_addr_w'(palette_depth - 1)) ? '0 : offset + 1'b1;
  end

endmodule

`default_nettype wire

//--- neo_pkg.sv
/* neopixel driver shared definitions
   timing at 12 MHz, bus widths and the frame phase type */
`default_nettype none

package neo_pkg;

  //////////////////////////////
  // chain and palette geometry
  //////////////////////////////
  localparam int num_pixels     = 8;    // LEDs in the chain
  localparam int pix_addr_w     = 3;    // pixel pointer width
  localparam int palette_depth  = 32;   // fading palette entries
  localparam int palette_addr_w = 5;    // palette address and offset
  localparam int color_w        = 15;   // packed 5:5:5 green, red, blue
  localparam int pixel_w        = 24;   // widened 8:8:8 as sent on the line
  localparam int bit_idx_w      = 5;    // bit index 0..23 inside a pixel

  //////////////////////////////
  // WS2812B bit timing
  //////////////////////////////
  // 83.3 ns clock, so 15 clocks make a 1250 ns bit
  localparam int bit_period = 15;
  localparam int bit1_hi    = 10;       // ~833 ns high for a one
  localparam int bit0_hi    = 5;        // ~417 ns high for a zero
  localparam int bit_cnt_w  = 4;        // counts 0..14

  //////////////////////////////
  // reset gap between frames
  //////////////////////////////
  localparam int tick_count  = 120;     // clocks per 10 us tick
  localparam int tick_cnt_w  = 7;
  localparam int reset_ticks = 7;       // 70 us gap, chain needs > 50 us
  localparam int gap_cnt_w   = 3;

  // gap while the chain latches, data while bits go out
  typedef enum logic {
    phase_gap,
    phase_data
  } frame_phase_t;

endpackage

`default_nettype wire
